/* list.f */
design/core_isa_pkg.sv
design/core_ctrl_pkg.sv
design/core_regfile.sv
design/core_decode.sv
design/core_bypass.sv
design/core_execute.sv
design/core_result.sv
design/core_top.sv
sim/tb_clock_gen.sv
sim/core_props.sv
sim/core_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the core testbench with Verilator; exit status is the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f list.f --top-module core_tb -o core_sim \
  && ./obj_dir/core_sim \
  || exit 1

/* sim/core_tb.sv */
`timescale 1ns/10ps
////////////////////////////////////////////////////////////
// Directed tests for the three-stage core
// Inputs change on the falling edge, retire sampled on the
// rising edge; APB slave adds 0 to 3 random wait states
// Expected retires come from an in-order register model
////////////////////////////////////////////////////////////
module core_tb import core_isa_pkg::*;;

  localparam int unsigned APB_ADDR_W = 12;
  localparam int          MEM_WORDS  = 2 ** (APB_ADDR_W - 2);
  // Sends over all tests including readbacks
  localparam int          N_INSTR    = 53;
  localparam int          MAX_CYCLES = N_INSTR * 8 + 200;

  logic                  clk;
  logic                  reset_i;
  logic                  instr_valid_i;
  instr_t                instr_i;
  logic                  instr_ready_o;
  logic                  psel_o;
  logic                  penable_o;
  logic [APB_ADDR_W-1:0] paddr_o;
  logic                  pready_i;
  word_t                 prdata_i;
  logic                  pslverr_i;
  logic                  retire_valid_o;
  rf_addr_t              retire_rd_o;
  word_t                 retire_data_o;

  word_t    mem [MEM_WORDS];
  word_t    model_rf [32];
  rf_addr_t exp_rd_q [$];
  word_t    exp_data_q [$];
  word_t    last_retire_data;
  string    test_name;
  int       cycle_count;
  int       wait_left;
  logic     apb_busy;

  tb_clock_gen u_clk (.clk_o(clk));

  core_top #(.APB_ADDR_W(APB_ADDR_W)) u_dut (
    .clk            (clk),
    .reset_i        (reset_i),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .instr_ready_o  (instr_ready_o),
    .psel_o         (psel_o),
    .penable_o      (penable_o),
    .paddr_o        (paddr_o),
    .pready_i       (pready_i),
    .prdata_i       (prdata_i),
    .pslverr_i      (pslverr_i),
    .retire_valid_o (retire_valid_o),
    .retire_rd_o    (retire_rd_o),
    .retire_data_o  (retire_data_o)
  );

  ////////////////////////////////////////////////////////////
  // Failure, compare tasks and timeout
  ////////////////////////////////////////////////////////////
  task automatic report_failure(string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic check_retire(rf_addr_t rd, word_t data);
    rf_addr_t exp_rd;
    word_t    exp_data;
    if (exp_rd_q.size() == 0) begin
      report_failure($sformatf("%s: unexpected retire of x%0d", test_name, rd));
    end else begin
      exp_rd   = exp_rd_q.pop_front();
      exp_data = exp_data_q.pop_front();
      last_retire_data = data;
      if (rd != exp_rd) begin
        report_failure($sformatf("ERROR %s retire rd expected %0d actual %0d",
                                 test_name, exp_rd, rd));
      end else if (data != exp_data) begin
        report_failure($sformatf("ERROR %s retire data expected %08h actual %08h",
                                 test_name, exp_data, data));
      end
    end
  endtask

  task automatic check_word(word_t exp, word_t act);
    if (act != exp) begin
      report_failure($sformatf("ERROR %s readback expected %08h actual %08h",
                               test_name, exp, act));
    end
  endtask

  always @(posedge clk) begin
    if (!reset_i && retire_valid_o) begin
      check_retire(retire_rd_o, retire_data_o);
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      report_failure("Timeout: the pipeline did not finish in time");
    end
  end

  ////////////////////////////////////////////////////////////
  // APB slave model
  ////////////////////////////////////////////////////////////
  always @(negedge clk) begin
    pready_i = 1'b0;
    if (psel_o && penable_o) begin
      // Wait count drawn on the first access cycle
      if (!apb_busy) begin
        apb_busy  = 1'b1;
        wait_left = int'($urandom % 4);
      end
      if (wait_left == 0) begin
        pready_i = 1'b1;
        prdata_i = mem[paddr_o[APB_ADDR_W-1:2]];
        apb_busy = 1'b0;
      end else begin
        wait_left--;
      end
    end else begin
      apb_busy = 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Instruction building and reference model
  ////////////////////////////////////////////////////////////
  function automatic instr_t make_instr(opcode_e op, rf_addr_t rd, rf_addr_t rs1,
                                        rf_addr_t rs2, int imm);
    instr_t ins;
    ins.opcode = op;
    ins.rd     = rd;
    ins.rs1    = rs1;
    ins.rs2    = rs2;
    ins.imm    = imm[12:0];
    return ins;
  endfunction

  // In-order result of one instruction on the model registers
  function automatic word_t model_result(instr_t ins);
    word_t a;
    word_t b;
    word_t imm_x;
    word_t addr;
    a     = model_rf[ins.rs1];
    b     = model_rf[ins.rs2];
    imm_x = {{19{ins.imm[12]}}, ins.imm};
    addr  = a + imm_x;
    case (ins.opcode)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_XOR:  return a ^ b;
      OP_ADDI: return a + imm_x;
      OP_LW:   return mem[addr[APB_ADDR_W-1:2]];
      default: return '0;
    endcase
  endfunction

  task automatic send(instr_t ins);
    word_t res;
    logic  rdy;
    res = model_result(ins);
    if ((ins.opcode >= 4'h1) && (ins.opcode <= 4'h6) && (ins.rd != '0)) begin
      model_rf[ins.rd] = res;
      exp_rd_q.push_back(ins.rd);
      exp_data_q.push_back(res);
    end
    rdy = 1'b0;
    while (!rdy) begin
      @(negedge clk);
      instr_valid_i = 1'b1;
      instr_i       = ins;
      // Ready settles after the slave updates pready
      #2;
      rdy = instr_ready_o;
      @(posedge clk);
    end
  endtask

  task automatic idle(int n);
    repeat (n) begin
      @(negedge clk);
      instr_valid_i = 1'b0;
    end
  endtask

  task automatic drain();
    idle(1);
    while (exp_rd_q.size() != 0) begin
      @(posedge clk);
    end
  endtask

  // Copy rs to x31 and compare the retired value
  task automatic readback(rf_addr_t rs);
    word_t exp;
    exp = model_rf[rs];
    send(make_instr(OP_ADDI, 5'd31, rs, 5'd0, 0));
    drain();
    check_word(exp, last_retire_data);
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////
  task automatic test_ex_forward();
    test_name = "ex_forward";
    send(make_instr(OP_ADDI, 5'd1, 5'd0, 5'd0, 100));
    send(make_instr(OP_ADDI, 5'd2, 5'd0, 5'd0, -7));
    send(make_instr(OP_ADD, 5'd3, 5'd1, 5'd2, 0));
    send(make_instr(OP_SUB, 5'd4, 5'd3, 5'd1, 0));
    send(make_instr(OP_XOR, 5'd5, 5'd4, 5'd3, 0));
    send(make_instr(OP_AND, 5'd6, 5'd5, 5'd4, 0));
    send(make_instr(OP_ADD, 5'd7, 5'd6, 5'd6, 0));
    readback(5'd7);
  endtask

  task automatic test_wb_rf_forward();
    test_name = "wb_rf_forward";
    send(make_instr(OP_ADDI, 5'd8, 5'd0, 5'd0, 55));
    send(make_instr(OP_ADDI, 5'd9, 5'd0, 5'd0, 3));
    // x8 two back comes from WB
    send(make_instr(OP_ADD, 5'd10, 5'd8, 5'd9, 0));
    send(make_instr(OP_ADDI, 5'd11, 5'd0, 5'd0, 1));
    send(make_instr(OP_ADDI, 5'd12, 5'd0, 5'd0, 2));
    // x10 three back comes from the register file
    send(make_instr(OP_SUB, 5'd13, 5'd10, 5'd12, 0));
    readback(5'd13);
  endtask

  task automatic test_load_use();
    int off;
    test_name = "load_use";
    for (int i = 0; i < 8; i++) begin
      off = int'($urandom % 1024) * 4;
      send(make_instr(OP_LW, 5'd14, 5'd0, 5'd0, off));
      send(make_instr(OP_ADD, 5'd15, 5'd14, 5'd1, 0));
    end
    // Loaded value used as the next load address
    send(make_instr(OP_LW, 5'd16, 5'd1, 5'd0, 8));
    send(make_instr(OP_LW, 5'd17, 5'd16, 5'd0, 0));
    send(make_instr(OP_XOR, 5'd18, 5'd17, 5'd16, 0));
    readback(5'd18);
  endtask

  task automatic test_x0();
    test_name = "x0";
    send(make_instr(OP_ADD, 5'd0, 5'd1, 5'd2, 0));
    send(make_instr(OP_ADDI, 5'd0, 5'd1, 5'd0, 5));
    // x0 is the destination in execute here
    send(make_instr(OP_ADD, 5'd19, 5'd0, 5'd2, 0));
    send(make_instr(OP_XOR, 5'd20, 5'd0, 5'd0, 0));
    readback(5'd0);
    readback(5'd19);
  endtask

  task automatic test_gaps();
    rf_addr_t rd;
    rf_addr_t rs1;
    rf_addr_t rs2;
    test_name = "gaps";
    for (int i = 0; i < 10; i++) begin
      rd  = rf_addr_t'(1 + ($urandom % 12));
      rs1 = rf_addr_t'(1 + ($urandom % 12));
      rs2 = rf_addr_t'(1 + ($urandom % 12));
      case ($urandom % 5)
        0:       send(make_instr(OP_ADD, rd, rs1, rs2, 0));
        1:       send(make_instr(OP_SUB, rd, rs1, rs2, 0));
        2:       send(make_instr(OP_AND, rd, rs1, rs2, 0));
        3:       send(make_instr(OP_XOR, rd, rs1, rs2, 0));
        default: send(make_instr(OP_LW, rd, 5'd0, 5'd0, int'($urandom % 1024) * 4));
      endcase
      idle(int'($urandom % 4));
    end
    readback(5'd3);
    readback(rd);
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    void'($urandom(17183));
    reset_i       = 1'b1;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    pready_i      = 1'b0;
    prdata_i      = '0;
    pslverr_i     = 1'b0;
    apb_busy      = 1'b0;
    wait_left     = 0;
    cycle_count   = 0;
    test_name     = "reset";
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = (i * 32'h01010101) ^ 32'h5A5A0000 ^ (i << 20);
    end
    for (int i = 0; i < 32; i++) begin
      model_rf[i] = '0;
    end
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset_i = 1'b0;
    #1;
    if (!instr_ready_o || psel_o || penable_o || retire_valid_o) begin
      report_failure("Outputs not in their reset state after reset");
    end

    test_ex_forward();
    test_wb_rf_forward();
    test_load_use();
    test_x0();
    test_gaps();

    drain();
    // Nothing may retire after the last expected item
    repeat (10) @(posedge clk);
    if (exp_rd_q.size() != 0) begin
      report_failure("Expected retires still pending at the end");
    end else begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule

/* sim/core_props.sv */
`timescale 1ns/10ps
////////////////////////////////////////////////////////////
// APB, retire and stall assertions on the core outputs
// Bound into core_top where the result stage APB/retire
// outputs and the bypass stall are visible side by side
////////////////////////////////////////////////////////////
module core_props #(
  parameter int unsigned APB_ADDR_W = 12
) (
  input logic                  clk,
  input logic                  reset_i,
  input logic                  psel,
  input logic                  penable,
  input logic                  pready,
  input logic [APB_ADDR_W-1:0] paddr,
  input logic                  retire_valid,
  input logic [4:0]            retire_rd,
  input logic                  load_stall,
  input logic                  instr_ready
);

  // Setup phase is followed by the access phase
  a_penable_follows: assert property (@(posedge clk) disable iff (reset_i)
    (psel && !penable) |=> (psel && penable))
    else $error("penable did not follow psel");

  // Address held from setup through the last access cycle
  a_paddr_stable: assert property (@(posedge clk) disable iff (reset_i)
    (psel && !(penable && pready)) |=> $stable(paddr))
    else $error("paddr changed during an APB transfer");

  a_no_x0_retire: assert property (@(posedge clk) disable iff (reset_i)
    retire_valid |-> (retire_rd != 5'd0))
    else $error("retire reported register x0");

  a_stall_blocks_ready: assert property (@(posedge clk) disable iff (reset_i)
    load_stall |-> !instr_ready)
    else $error("instr_ready high during load stall");

endmodule

bind core_top core_props #(
  .APB_ADDR_W (APB_ADDR_W)
) u_props (
  .clk          (clk),
  .reset_i      (reset_i),
  .psel         (psel_o),
  .penable      (penable_o),
  .pready       (pready_i),
  .paddr        (paddr_o),
  .retire_valid (retire_valid_o),
  .retire_rd    (retire_rd_o),
  .load_stall   (ctrl_byp.load_stall),
  .instr_ready  (instr_ready_o)
);

/* sim/tb_clock_gen.sv */
`timescale 1ns/10ps
////////////////////////////////////////////////////////////
// Free-running testbench clock, starts low at time zero
////////////////////////////////////////////////////////////
module tb_clock_gen #(
  parameter realtime PERIOD_NS = 10.0
) (
  output logic clk_o
);

  initial clk_o = 1'b0;

  // Half period per toggle
  always #(PERIOD_NS / 2.0) clk_o = ~clk_o;

endmodule

/* design/core_top.sv */
`timescale 1ns/10ps
////////////////////////////////////////////////////////////
// Three-stage integer core: decode, execute, result
// One instruction accepted per valid/ready edge; loads read
// over APB in the result stage and stall it on wait states
////////////////////////////////////////////////////////////
module core_top import core_isa_pkg::*, core_ctrl_pkg::*; #(
  parameter int unsigned APB_ADDR_W = 12
) (
  input  logic                  clk,
  input  logic                  reset_i,
  // Instruction stream
  input  logic                  instr_valid_i,
  input  instr_t                instr_i,
  output logic                  instr_ready_o,
  // APB data port
  output logic                  psel_o,
  output logic                  penable_o,
  output logic [APB_ADDR_W-1:0] paddr_o,
  input  logic                  pready_i,
  input  word_t                 prdata_i,
  input  logic                  pslverr_i,
  // Retire
  output logic                  retire_valid_o,
  output rf_addr_t              retire_rd_o,
  output word_t                 retire_data_o
);

  decoded_t    dec;
  logic        dec_valid;
  ctrl_byp_t   ctrl_byp;
  id_ex_pipe_t id_ex_pipe;
  ex_wb_pipe_t ex_wb_pipe;
  word_t       rdata_a;
  word_t       rdata_b;
  word_t       ex_result;
  word_t       wb_fw;
  logic        wb_ready;
  logic        rf_we;
  rf_addr_t    rf_waddr;
  word_t       rf_wdata;

  core_decode u_decode (
    .clk           (clk),
    .reset_i       (reset_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .instr_ready_o (instr_ready_o),
    .ctrl_byp_i    (ctrl_byp),
    .wb_ready_i    (wb_ready),
    .dec_o         (dec),
    .dec_valid_o   (dec_valid),
    .rdata_a_i     (rdata_a),
    .rdata_b_i     (rdata_b),
    .ex_fw_i       (ex_result),
    .wb_fw_i       (wb_fw),
    .id_ex_pipe_o  (id_ex_pipe)
  );

  core_bypass u_bypass (
    .dec_i        (dec),
    .dec_valid_i  (dec_valid),
    .id_ex_pipe_i (id_ex_pipe),
    .ex_wb_pipe_i (ex_wb_pipe),
    .wb_ready_i   (wb_ready),
    .ctrl_byp_o   (ctrl_byp)
  );

  // Read addresses come from the instruction held in decode
  core_regfile u_regfile (
    .clk       (clk),
    .reset_i   (reset_i),
    .raddr_a_i (dec.rs1),
    .raddr_b_i (dec.rs2),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b),
    .we_i      (rf_we),
    .waddr_i   (rf_waddr),
    .wdata_i   (rf_wdata)
  );

  core_execute u_execute (
    .clk          (clk),
    .reset_i      (reset_i),
    .wb_ready_i   (wb_ready),
    .id_ex_pipe_i (id_ex_pipe),
    .ex_result_o  (ex_result),
    .ex_wb_pipe_o (ex_wb_pipe)
  );

  core_result #(
    .APB_ADDR_W (APB_ADDR_W)
  ) u_result (
    .clk            (clk),
    .reset_i        (reset_i),
    .ex_wb_pipe_i   (ex_wb_pipe),
    .wb_ready_o     (wb_ready),
    .wb_fw_o        (wb_fw),
    .rf_we_o        (rf_we),
    .rf_waddr_o     (rf_waddr),
    .rf_wdata_o     (rf_wdata),
    .psel_o         (psel_o),
    .penable_o      (penable_o),
    .paddr_o        (paddr_o),
    .pready_i       (pready_i),
    .prdata_i       (prdata_i),
    .pslverr_i      (pslverr_i),
    .retire_valid_o (retire_valid_o),
    .retire_rd_o    (retire_rd_o),
    .retire_data_o  (retire_data_o)
  );

endmodule

/* design/core_result.sv */
`timescale 1ns/10ps
////////////////////////////////////////////////////////////
// Result stage: APB read for loads, regfile write, retire
// A load spends one cycle in IDLE, one in SETUP, then ACCESS
// until pready. pslverr is not checked, data is written
// paddr takes the low APB_ADDR_W bits of the load address
////////////////////////////////////////////////////////////
module core_result import core_isa_pkg::*, core_ctrl_pkg::*; #(
  parameter int unsigned APB_ADDR_W = 12
) (
  input  logic                  clk,
  input  logic                  reset_i,
  input  ex_wb_pipe_t           ex_wb_pipe_i,
  output logic                  wb_ready_o,
  output word_t                 wb_fw_o,
  // Register file write port
  output logic                  rf_we_o,
  output rf_addr_t              rf_waddr_o,
  output word_t                 rf_wdata_o,
  // APB master, read only
  output logic                  psel_o,
  output logic                  penable_o,
  output logic [APB_ADDR_W-1:0] paddr_o,
  input  logic                  pready_i,
  input  word_t                 prdata_i,
  input  logic                  pslverr_i,
  // Retire port
  output logic                  retire_valid_o,
  output rf_addr_t              retire_rd_o,
  output word_t                 retire_data_o
);

  typedef enum logic [1:0] {IDLE, SETUP, ACCESS} apb_state_e;

  apb_state_e state_q;
  apb_state_e state_d;
  logic       load_wb;

  assign load_wb = ex_wb_pipe_i.valid && ex_wb_pipe_i.lsu_en;

  ////////////////////////////////////////////////////////////
  // APB read FSM
  ////////////////////////////////////////////////////////////
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (load_wb) state_d = SETUP;
      SETUP:   state_d = ACCESS;
      ACCESS:  if (pready_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Address comes straight from the held pipe register
  assign psel_o    = (state_q != IDLE);
  assign penable_o = (state_q == ACCESS);
  assign paddr_o   = ex_wb_pipe_i.result[APB_ADDR_W-1:0];

  // Only a load short of its pready holds the pipe
  assign wb_ready_o = !load_wb || ((state_q == ACCESS) && pready_i);

  ////////////////////////////////////////////////////////////
  // Write back and retire
  ////////////////////////////////////////////////////////////
  // Error response ignored, pslverr_i has no effect on the data
  assign rf_wdata_o = ex_wb_pipe_i.lsu_en ? prdata_i : ex_wb_pipe_i.result;
  assign wb_fw_o    = rf_wdata_o;
  assign rf_we_o    = ex_wb_pipe_i.valid && ex_wb_pipe_i.rf_we && wb_ready_o;
  assign rf_waddr_o = ex_wb_pipe_i.rf_waddr;

  // One pulse per register write, sampled on the write edge
  assign retire_valid_o = rf_we_o;
  assign retire_rd_o    = rf_waddr_o;
  assign retire_data_o  = rf_wdata_o;

endmodule

/* design/core_execute.sv */
`timescale 1ns/10ps
////////////////////////////////////////////////////////////
// Execute stage: ALU and load address generation
// ex_result_o is combinational and feeds the EX forward
// path; the register holds while WB is not ready
////////////////////////////////////////////////////////////
module core_execute import core_isa_pkg::*, core_ctrl_pkg::*; (
  input  logic        clk,
  input  logic        reset_i,
  input  logic        wb_ready_i,
  input  id_ex_pipe_t id_ex_pipe_i,
  output word_t       ex_result_o,
  output ex_wb_pipe_t ex_wb_pipe_o
);

  ex_wb_pipe_t ex_wb_q;

  // ALU, LW shares the ADDI adder for its address
  always_comb begin
    case (id_ex_pipe_i.opcode)
      OP_ADD:        ex_result_o = id_ex_pipe_i.operand_a + id_ex_pipe_i.operand_b;
      OP_SUB:        ex_result_o = id_ex_pipe_i.operand_a - id_ex_pipe_i.operand_b;
      OP_AND:        ex_result_o = id_ex_pipe_i.operand_a & id_ex_pipe_i.operand_b;
      OP_XOR:        ex_result_o = id_ex_pipe_i.operand_a ^ id_ex_pipe_i.operand_b;
      OP_ADDI, OP_LW: ex_result_o = id_ex_pipe_i.operand_a + id_ex_pipe_i.imm;
      default:       ex_result_o = '0;
    endcase
  end

  // Execute to result register
  always_ff @(posedge clk) begin
    if (reset_i) begin
      ex_wb_q <= '0;
    end else if (wb_ready_i) begin
      ex_wb_q.valid    <= id_ex_pipe_i.valid;
      ex_wb_q.rf_we    <= id_ex_pipe_i.rf_we;
      ex_wb_q.lsu_en   <= id_ex_pipe_i.lsu_en;
      ex_wb_q.rf_waddr <= id_ex_pipe_i.rf_waddr;
      ex_wb_q.result   <= ex_result_o;
    end
  end

  assign ex_wb_pipe_o = ex_wb_q;

endmodule

/* design/core_bypass.sv */
`timescale 1ns/10ps
////////////////////////////////////////////////////////////
// Hazard detection and forward select for the two decode
// read ports. Purely combinational; matches are qualified
// by decode valid, read enable and a non-zero address
////////////////////////////////////////////////////////////
module core_bypass import core_isa_pkg::*, core_ctrl_pkg::*; (
  input  decoded_t    dec_i,
  input  logic        dec_valid_i,
  input  id_ex_pipe_t id_ex_pipe_i,
  input  ex_wb_pipe_t ex_wb_pipe_i,
  input  logic        wb_ready_i,
  output ctrl_byp_t   ctrl_byp_o
);

  // Live destinations in EX and WB
  logic rf_we_ex;
  logic rf_we_wb;
  logic load_ex;
  logic load_wb;

  // Bit 0 is operand a (rs1), bit 1 operand b (rs2)
  logic [1:0] rd_ex_match;
  logic [1:0] rd_wb_match;

  assign rf_we_ex = id_ex_pipe_i.valid && id_ex_pipe_i.rf_we;
  assign rf_we_wb = ex_wb_pipe_i.valid && ex_wb_pipe_i.rf_we;
  assign load_ex  = rf_we_ex && id_ex_pipe_i.lsu_en;
  assign load_wb  = rf_we_wb && ex_wb_pipe_i.lsu_en;

  // Address compare, x0 reads never match
  assign rd_ex_match[0] = dec_valid_i && dec_i.re_a && (dec_i.rs1 != '0) &&
                          (dec_i.rs1 == id_ex_pipe_i.rf_waddr);
  assign rd_ex_match[1] = dec_valid_i && dec_i.re_b && (dec_i.rs2 != '0) &&
                          (dec_i.rs2 == id_ex_pipe_i.rf_waddr);
  assign rd_wb_match[0] = dec_valid_i && dec_i.re_a && (dec_i.rs1 != '0) &&
                          (dec_i.rs1 == ex_wb_pipe_i.rf_waddr);
  assign rd_wb_match[1] = dec_valid_i && dec_i.re_b && (dec_i.rs2 != '0) &&
                          (dec_i.rs2 == ex_wb_pipe_i.rf_waddr);

  ////////////////////////////////////////////////////////////
  // Load-use stall
  ////////////////////////////////////////////////////////////
  // Load in EX has only its address, load in WB waiting on
  // APB has no data yet; once pready arrives WB forwards it
  always_comb begin
    ctrl_byp_o.load_stall = 1'b0;
    if ((load_ex && |rd_ex_match) ||
        (load_wb && !wb_ready_i && |rd_wb_match)) begin
      ctrl_byp_o.load_stall = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Forward select
  ////////////////////////////////////////////////////////////
  always_comb begin
    ctrl_byp_o.operand_a_fw_sel = SEL_REGFILE;
    ctrl_byp_o.operand_b_fw_sel = SEL_REGFILE;

    // WB first, then EX overrides as the younger writer
    if (rf_we_wb) begin
      if (rd_wb_match[0]) begin
        ctrl_byp_o.operand_a_fw_sel = SEL_FW_WB;
      end
      if (rd_wb_match[1]) begin
        ctrl_byp_o.operand_b_fw_sel = SEL_FW_WB;
      end
    end

    // EX select with a load in EX is a don't care, stall wins
    if (rf_we_ex) begin
      if (rd_ex_match[0]) begin
        ctrl_byp_o.operand_a_fw_sel = SEL_FW_EX;
      end
      if (rd_ex_match[1]) begin
        ctrl_byp_o.operand_b_fw_sel = SEL_FW_EX;
      end
    end
  end

endmodule

/* design/core_decode.sv */
`timescale 1ns/10ps
////////////////////////////////////////////////////////////
// Decode stage: instruction register, field decode and
// operand forwarding. instr_ready_o drops on load_stall or
// while WB waits on APB; a load_stall sends a bubble to EX
////////////////////////////////////////////////////////////
module core_decode import core_isa_pkg::*, core_ctrl_pkg::*; (
  input  logic        clk,
  input  logic        reset_i,
  // Instruction handshake
  input  logic        instr_valid_i,
  input  instr_t      instr_i,
  output logic        instr_ready_o,
  // Stall and forward control
  input  ctrl_byp_t   ctrl_byp_i,
  input  logic        wb_ready_i,
  // Decoded instruction, also the regfile read addresses
  output decoded_t    dec_o,
  output logic        dec_valid_o,
  // Operand sources
  input  word_t       rdata_a_i,
  input  word_t       rdata_b_i,
  input  word_t       ex_fw_i,
  input  word_t       wb_fw_i,
  output id_ex_pipe_t id_ex_pipe_o
);

  instr_t      instr_q;
  logic        valid_q;
  logic        stall_id;
  id_ex_pipe_t id_ex_q;

  // Pick one operand source, EX/WB priority is set in bypass
  function automatic word_t fw_mux(fw_sel_e sel, word_t rf_val, word_t ex_val, word_t wb_val);
    word_t val;
    case (sel)
      SEL_FW_EX: val = ex_val;
      SEL_FW_WB: val = wb_val;
      default:   val = rf_val;
    endcase
    return val;
  endfunction

  assign stall_id      = ctrl_byp_i.load_stall || !wb_ready_i;
  assign instr_ready_o = !stall_id;
  assign dec_valid_o   = valid_q;

  // Instruction register, advances whenever decode is not held
  always_ff @(posedge clk) begin
    if (reset_i) begin
      valid_q <= 1'b0;
      instr_q <= '0;
    end else if (!stall_id) begin
      valid_q <= instr_valid_i;
      if (instr_valid_i) begin
        instr_q <= instr_i;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Field decode
  ////////////////////////////////////////////////////////////
  always_comb begin
    dec_o        = '0;
    dec_o.opcode = opcode_e'(instr_q.opcode);
    dec_o.rd     = instr_q.rd;
    dec_o.rs1    = instr_q.rs1;
    dec_o.rs2    = instr_q.rs2;
    dec_o.imm    = {{19{instr_q.imm[12]}}, instr_q.imm};
    case (dec_o.opcode)
      OP_ADD, OP_SUB, OP_AND, OP_XOR: begin
        dec_o.re_a  = 1'b1;
        dec_o.re_b  = 1'b1;
        dec_o.rf_we = 1'b1;
      end
      OP_ADDI: begin
        dec_o.re_a  = 1'b1;
        dec_o.rf_we = 1'b1;
      end
      OP_LW: begin
        dec_o.re_a   = 1'b1;
        dec_o.rf_we  = 1'b1;
        dec_o.lsu_en = 1'b1;
      end
      default: begin
        // Unknown code, no-op
      end
    endcase
    // Writes to x0 are dropped here so they never retire
    if (instr_q.rd == '0) begin
      dec_o.rf_we = 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Decode to execute register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset_i) begin
      id_ex_q <= '0;
    end else if (wb_ready_i) begin
      // Bubble while the operand is still owed by a load
      id_ex_q.valid     <= valid_q && !ctrl_byp_i.load_stall;
      id_ex_q.rf_we     <= dec_o.rf_we;
      id_ex_q.lsu_en    <= dec_o.lsu_en;
      id_ex_q.rf_waddr  <= dec_o.rd;
      id_ex_q.opcode    <= dec_o.opcode;
      id_ex_q.operand_a <= fw_mux(ctrl_byp_i.operand_a_fw_sel, rdata_a_i, ex_fw_i, wb_fw_i);
      id_ex_q.operand_b <= fw_mux(ctrl_byp_i.operand_b_fw_sel, rdata_b_i, ex_fw_i, wb_fw_i);
      id_ex_q.imm       <= dec_o.imm;
    end
  end

  assign id_ex_pipe_o = id_ex_q;

endmodule

/* design/core_regfile.sv */
`timescale 1ns/10ps
////////////////////////////////////////////////////////////
// 32 x 32-bit register file, two async reads, one write
// A write and a read of the same register in one cycle
// returns the old value; decode forwards from WB instead
////////////////////////////////////////////////////////////
module core_regfile import core_isa_pkg::*; (
  input  logic     clk,
  input  logic     reset_i,
  input  rf_addr_t raddr_a_i,
  input  rf_addr_t raddr_b_i,
  output word_t    rdata_a_o,
  output word_t    rdata_b_o,
  input  logic     we_i,
  input  rf_addr_t waddr_i,
  input  word_t    wdata_i
);

  word_t regs_q [32];

  // Write port, x0 is never written
  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int i = 0; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Read ports, x0 forced to zero
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

/* design/core_ctrl_pkg.sv */
////////////////////////////////////////////////////////////
// Pipeline register and bypass control types
// Both pipe structs carry their own valid bit; a cleared
// valid marks a bubble and qualifies every other field
////////////////////////////////////////////////////////////
package core_ctrl_pkg;

  import core_isa_pkg::*;

  // Decode to execute
  typedef struct packed {
    logic     valid;
    logic     rf_we;
    logic     lsu_en;
    rf_addr_t rf_waddr;
    opcode_e  opcode;
    word_t    operand_a;
    word_t    operand_b;
    word_t    imm;
  } id_ex_pipe_t;

  // Execute to result; result holds the load address for LW
  typedef struct packed {
    logic     valid;
    logic     rf_we;
    logic     lsu_en;
    rf_addr_t rf_waddr;
    word_t    result;
  } ex_wb_pipe_t;

  // Operand source in decode
  typedef enum logic [1:0] {
    SEL_REGFILE = 2'b00,
    SEL_FW_EX   = 2'b01,
    SEL_FW_WB   = 2'b10
  } fw_sel_e;

  // Bypass controller to decode
  typedef struct packed {
    logic    load_stall;
    fw_sel_e operand_a_fw_sel;
    fw_sel_e operand_b_fw_sel;
  } ctrl_byp_t;

endpackage

/* design/core_isa_pkg.sv */
////////////////////////////////////////////////////////////
// Instruction set types of the three-stage integer core
// Instruction word layout, from the top bit down:
//   opcode[31:28] rd[27:23] rs1[22:18] rs2[17:13] imm[12:0]
// Any opcode outside opcode_e decodes as a no-op
////////////////////////////////////////////////////////////
package core_isa_pkg;

  // Data word and register index
  typedef logic [31:0] word_t;
  typedef logic [4:0]  rf_addr_t;
  typedef logic [12:0] imm13_t;

  // Raw instruction word as it arrives on the handshake
  typedef struct packed {
    logic [3:0] opcode;
    rf_addr_t   rd;
    rf_addr_t   rs1;
    rf_addr_t   rs2;
    imm13_t     imm;
  } instr_t;

  // Code 0 stays free so an all-zero word is a no-op
  typedef enum logic [3:0] {
    OP_ADD  = 4'h1,
    OP_SUB  = 4'h2,
    OP_AND  = 4'h3,
    OP_XOR  = 4'h4,
    OP_ADDI = 4'h5,
    OP_LW   = 4'h6
  } opcode_e;

  // Instruction after field decode in the decode stage
  typedef struct packed {
    opcode_e  opcode;
    rf_addr_t rd;
    rf_addr_t rs1;
    rf_addr_t rs2;
    word_t    imm;     // sign extended
    logic     re_a;    // rs1 is read
    logic     re_b;    // rs2 is read
    logic     rf_we;   // writes rd, never set for x0
    logic     lsu_en;  // load over APB
  } decoded_t;

endpackage
